/* project.f */
source/csr_pkg.sv
source/csr_apb_slave.sv
source/priv_fsm.sv
source/csr_counters.sv
source/csr_regfile.sv
source/csr_top.sv
verification/csr_tb.sv

/* Makefile */
# Verilator flow for the CSR unit.
TOP ?= csr_tb
FLAGS ?= --timing --assert
SEED ?= 32'h7005e437
OBJ_DIR ?= obj_dir
FILELIST ?= project.f
PASS_MSG := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only $(FLAGS) --top-module $(TOP) -GSEED="$(SEED)" -f $(FILELIST)

sim:
	verilator --binary $(FLAGS) --top-module $(TOP) -GSEED="$(SEED)" \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;

	parameter logic [31:0] SEED = 32'h7005e437;
	localparam int TIMER_DIV = 8;
	localparam int MAX_CYCLES = 2000; // whole run is a few hundred cycles.
	localparam int DRIVE_DELAY = 2;

	logic clk, rst;
	logic psel, penable, pwrite;
	csr_pkg::csr_addr_t paddr;
	csr_pkg::csr_data_t pwdata, prdata;
	logic pready, pslverr;
	logic exception, exc_leave, inst_retired, ext_intr;
	csr_pkg::trap_info_t trap;
	csr_pkg::csr_data_t exc_handler_addr, exc_continue_addr;
	logic has_intr;
	csr_pkg::intr_idx_t intr_index;

	integer seed;
	int cycle_count;
	int prop_errs;
	int prop_mark;
	int test_errs;
	int tests_run;
	int tests_failed;
	string test_name;

	csr_top #(.TIMER_DIV(TIMER_DIV)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// setup, wait state, then ready.
	a_three_cycles: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> !pready ##1 pready)
	else begin
		$display("transfer to %h did not finish in three cycles", paddr);
		prop_errs++;
	end

	a_err_with_ready: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
	else begin
		$display("pslverr came without pready");
		prop_errs++;
	end

	a_idle_not_ready: assert property (@(posedge clk) disable iff (rst) !psel |-> !pready)
	else begin
		$display("pready high on an idle bus");
		prop_errs++;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic expect_value(input string what, input csr_pkg::csr_data_t exp,
			input csr_pkg::csr_data_t act);
		assert (act === exp)
		else begin
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond)
		else begin
			$display("%s: %s", test_name, what);
			test_errs++;
		end
	endtask

	task automatic apb_transfer(input logic write, input csr_pkg::csr_addr_t a,
			input csr_pkg::csr_data_t d, input logic exp_err,
			output csr_pkg::csr_data_t rdata);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = a;
		pwdata = d;
		next_cycle();
		penable = 1'b1;
		do
			next_cycle();
		while (!pready);
		rdata = prdata;
		expect_value($sformatf("pslverr at %h", a), 32'(exp_err), 32'(pslverr));
		next_cycle(); // completing edge.
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t d,
			input logic exp_err);
		csr_pkg::csr_data_t unused_rd;
		apb_transfer(1'b1, a, d, exp_err, unused_rd);
	endtask

	task automatic apb_read(input csr_pkg::csr_addr_t a, input logic exp_err,
			output csr_pkg::csr_data_t rdata);
		apb_transfer(1'b0, a, '0, exp_err, rdata);
	endtask

	task automatic read_check(input string what, input csr_pkg::csr_addr_t a,
			input csr_pkg::csr_data_t exp, input logic exp_err);
		csr_pkg::csr_data_t rdata;
		apb_read(a, exp_err, rdata);
		expect_value(what, exp, rdata);
	endtask

	task automatic pulse_exception(output csr_pkg::trap_info_t rec);
		rec.cause = $random(seed);
		rec.pc = $random(seed);
		rec.value = $random(seed);
		trap = rec;
		exception = 1'b1;
		next_cycle();
		exception = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		prop_mark = prop_errs;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0 && prop_errs == prop_mark) begin
			$display("test %s: pass", test_name);
		end else begin
			tests_failed++;
			$display("test %s: fail", test_name);
		end
	endtask

	initial begin
		csr_pkg::csr_data_t rdata, wval, r_scratch, r_stvec, r_sie, c1, c2;
		csr_pkg::trap_info_t rec;
		int n_ret, n;

		seed = SEED;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exception = 1'b0;
		exc_leave = 1'b0;
		trap = '0;
		inst_retired = 1'b0;
		ext_intr = 1'b0;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		start_test("reset");
		expect_value("pready", '0, 32'(pready));
		expect_value("pslverr", '0, 32'(pslverr));
		expect_value("has_intr", '0, 32'(has_intr));
		read_check("sstatus", csr_pkg::ADDR_SSTATUS, '0, 1'b0);
		read_check("stvec", csr_pkg::ADDR_STVEC, '0, 1'b0);
		finish_test();

		start_test("round_trip");
		r_scratch = $random(seed);
		r_stvec = $random(seed);
		r_sie = $random(seed);
		apb_write(csr_pkg::ADDR_SSCRATCH, r_scratch, 1'b0);
		apb_write(csr_pkg::ADDR_STVEC, r_stvec, 1'b0);
		apb_write(csr_pkg::ADDR_SIE, r_sie, 1'b0);
		read_check("sscratch", csr_pkg::ADDR_SSCRATCH, r_scratch, 1'b0);
		read_check("stvec", csr_pkg::ADDR_STVEC, r_stvec, 1'b0);
		read_check("sie", csr_pkg::ADDR_SIE, r_sie, 1'b0);
		expect_value("exc_handler_addr", r_stvec, exc_handler_addr);
		wval = ($random(seed) & 32'h3fff_ffff) | 32'h8000_0000; // far above the cycle count.
		apb_write(csr_pkg::ADDR_CYCLE, wval, 1'b0);
		apb_read(csr_pkg::ADDR_CYCLE, 1'b0, rdata);
		expect_true(rdata < 32'h8000_0000, "cycle counter took a host write");
		finish_test();

		start_test("trap");
		apb_write(csr_pkg::ADDR_SSTATUS, 32'd1 << csr_pkg::SSTATUS_SIE, 1'b0);
		pulse_exception(rec);
		read_check("sepc", csr_pkg::ADDR_SEPC, rec.pc, 1'b0);
		read_check("scause", csr_pkg::ADDR_SCAUSE, rec.cause, 1'b0);
		read_check("stval", csr_pkg::ADDR_STVAL, rec.value, 1'b0);
		expect_value("exc_continue_addr", rec.pc, exc_continue_addr);
		read_check("sstatus after entry", csr_pkg::ADDR_SSTATUS,
			(32'd1 << csr_pkg::SSTATUS_SPP) | (32'd1 << csr_pkg::SSTATUS_SPIE), 1'b0);
		apb_write(csr_pkg::ADDR_SSTATUS, 32'd1 << csr_pkg::SSTATUS_SPIE, 1'b0);
		exc_leave = 1'b1;
		next_cycle();
		exc_leave = 1'b0;
		// spp was zero, so now in user mode.
		read_check("sstatus after return", csr_pkg::ADDR_SSTATUS,
			(32'd1 << csr_pkg::SSTATUS_SPIE) | (32'd1 << csr_pkg::SSTATUS_SIE), 1'b1);
		finish_test();

		start_test("privilege");
		apb_write(csr_pkg::ADDR_SSCRATCH, ~r_scratch, 1'b1);
		apb_read(csr_pkg::ADDR_CYCLE, 1'b0, rdata);
		apb_read(csr_pkg::ADDR_TIME, 1'b0, rdata);
		apb_read(csr_pkg::ADDR_INSTRET, 1'b0, rdata);
		exc_leave = 1'b1; // return on the same edge, entry must win.
		pulse_exception(rec);
		exc_leave = 1'b0;
		read_check("sscratch", csr_pkg::ADDR_SSCRATCH, r_scratch, 1'b0);
		read_check("sstatus", csr_pkg::ADDR_SSTATUS, 32'd1 << csr_pkg::SSTATUS_SPIE, 1'b0);
		finish_test();

		start_test("interrupts");
		apb_write(csr_pkg::ADDR_SIE, (32'd1 << csr_pkg::SIP_TIMER_BIT) |
			(32'd1 << csr_pkg::SIP_EXT_BIT), 1'b0);
		apb_write(csr_pkg::ADDR_SIP, '0, 1'b0);
		apb_write(csr_pkg::ADDR_SSTATUS, 32'd1 << csr_pkg::SSTATUS_SIE, 1'b0);
		n = 0;
		while (!has_intr && n < 2 * TIMER_DIV) begin
			next_cycle();
			n++;
		end
		expect_true(has_intr, "has_intr did not rise within two timer periods");
		expect_value("timer intr_index", 32'(csr_pkg::SIP_TIMER_BIT), 32'(intr_index));
		// timer masked so its next tick cannot outrank the external source.
		apb_write(csr_pkg::ADDR_SIE, 32'd1 << csr_pkg::SIP_EXT_BIT, 1'b0);
		apb_write(csr_pkg::ADDR_SIP, '0, 1'b0);
		expect_value("has_intr after sip clear", '0, 32'(has_intr));
		ext_intr = 1'b1;
		next_cycle();
		ext_intr = 1'b0;
		expect_value("has_intr after ext_intr", 32'd1, 32'(has_intr));
		expect_value("ext intr_index", 32'(csr_pkg::SIP_EXT_BIT), 32'(intr_index));
		apb_write(csr_pkg::ADDR_SIE, '0, 1'b0);
		expect_value("has_intr after sie clear", '0, 32'(has_intr));
		finish_test();

		start_test("counters");
		n_ret = 4 + ($random(seed) & 7);
		for (int i = 0; i < n_ret; i++) begin
			inst_retired = 1'b1;
			next_cycle();
			inst_retired = 1'b0;
			next_cycle();
		end
		read_check("instret", csr_pkg::ADDR_INSTRET, 32'(n_ret), 1'b0);
		apb_read(csr_pkg::ADDR_CYCLE, 1'b0, c1);
		apb_write(csr_pkg::ADDR_SSCRATCH, $random(seed), 1'b0);
		apb_write(csr_pkg::ADDR_SSCRATCH, $random(seed), 1'b0);
		apb_read(csr_pkg::ADDR_CYCLE, 1'b0, c2);
		expect_value("cycle delta", 32'd3 * 32'd3, c2 - c1); // three transfers apart.
		apb_read(csr_pkg::ADDR_TIME, 1'b0, rdata);
		expect_true(rdata != 0, "time still zero long after TIMER_DIV cycles");
		read_check("cycleh", csr_pkg::ADDR_CYCLEH, '0, 1'b0);
		read_check("timeh", csr_pkg::ADDR_TIMEH, '0, 1'b0);
		read_check("instreth", csr_pkg::ADDR_INSTRETH, '0, 1'b0);
		finish_test();

		$display("%0d tests run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* source/csr_top.sv */
`timescale 1ns/1ps

module csr_top #(
	parameter int TIMER_DIV = 8
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input csr_pkg::csr_addr_t paddr,
	input csr_pkg::csr_data_t pwdata,
	output csr_pkg::csr_data_t prdata,
	output logic pready,
	output logic pslverr,
	input logic exception,
	input logic exc_leave,
	input csr_pkg::trap_info_t trap,
	input logic inst_retired,
	input logic ext_intr,
	output csr_pkg::csr_data_t exc_handler_addr,
	output csr_pkg::csr_data_t exc_continue_addr,
	output logic has_intr,
	output csr_pkg::intr_idx_t intr_index
);

	csr_pkg::csr_addr_t addr;
	csr_pkg::csr_wr_t wr;
	csr_pkg::csr_data_t rd_data;
	csr_pkg::csr_data_t sstatus;
	csr_pkg::priv_e mode;
	csr_pkg::counters_t counters;
	logic timer_tick;

	csr_apb_slave u_apb (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mode(mode), .rd_data(rd_data), .addr(addr), .wr(wr)
	);

	priv_fsm u_priv (
		.clk(clk), .rst(rst),
		.exception(exception), .exc_leave(exc_leave),
		.wr(wr), .mode(mode), .sstatus(sstatus)
	);

	csr_counters #(.TIMER_DIV(TIMER_DIV)) u_counters (
		.clk(clk), .rst(rst),
		.inst_retired(inst_retired),
		.counters(counters), .timer_tick(timer_tick)
	);

	csr_regfile u_regs (
		.clk(clk), .rst(rst),
		.addr(addr), .wr(wr), .rd_data(rd_data),
		.mode(mode), .sstatus(sstatus), .counters(counters),
		.timer_tick(timer_tick), .ext_intr(ext_intr),
		.exception(exception), .trap(trap),
		.exc_handler_addr(exc_handler_addr), .exc_continue_addr(exc_continue_addr),
		.has_intr(has_intr), .intr_index(intr_index)
	);

endmodule

/* source/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile (
	input logic clk,
	input logic rst,
	input csr_pkg::csr_addr_t addr,
	input csr_pkg::csr_wr_t wr,
	output csr_pkg::csr_data_t rd_data,
	input csr_pkg::priv_e mode,
	input csr_pkg::csr_data_t sstatus,
	input csr_pkg::counters_t counters,
	input logic timer_tick,
	input logic ext_intr,
	input logic exception,
	input csr_pkg::trap_info_t trap,
	output csr_pkg::csr_data_t exc_handler_addr,
	output csr_pkg::csr_data_t exc_continue_addr,
	output logic has_intr,
	output csr_pkg::intr_idx_t intr_index
);

	csr_pkg::csr_data_t sie, stvec, sscratch, sepc, scause, stval, sip;
	csr_pkg::csr_data_t pending;
	logic intr_gate;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sie <= '0;
			stvec <= '0;
			sscratch <= '0;
			sepc <= '0;
			scause <= '0;
			stval <= '0;
			sip <= '0;
		end else begin
			if (wr.en) begin
				case (wr.addr)
					csr_pkg::ADDR_SIE: sie <= wr.data;
					csr_pkg::ADDR_STVEC: stvec <= wr.data;
					csr_pkg::ADDR_SSCRATCH: sscratch <= wr.data;
					csr_pkg::ADDR_SEPC: sepc <= wr.data;
					csr_pkg::ADDR_SCAUSE: scause <= wr.data;
					csr_pkg::ADDR_STVAL: stval <= wr.data;
					csr_pkg::ADDR_SIP: sip <= wr.data;
					default: ;
				endcase
			end

			// trap capture overrides a write on the same edge.
			if (exception) begin
				sepc <= trap.pc;
				stval <= trap.value;
				scause <= trap.cause;
			end

			if (timer_tick)
				sip[csr_pkg::SIP_TIMER_BIT] <= 1'b1;
			if (ext_intr)
				sip[csr_pkg::SIP_EXT_BIT] <= 1'b1;
		end
	end

	always_comb begin
		rd_data = '0; // unmapped reads zero.
		case (addr)
			csr_pkg::ADDR_SSTATUS: rd_data = sstatus;
			csr_pkg::ADDR_SIE: rd_data = sie;
			csr_pkg::ADDR_STVEC: rd_data = stvec;
			csr_pkg::ADDR_SSCRATCH: rd_data = sscratch;
			csr_pkg::ADDR_SEPC: rd_data = sepc;
			csr_pkg::ADDR_SCAUSE: rd_data = scause;
			csr_pkg::ADDR_STVAL: rd_data = stval;
			csr_pkg::ADDR_SIP: rd_data = sip;
			csr_pkg::ADDR_CYCLE: rd_data = counters.cycle_cnt[31:0];
			csr_pkg::ADDR_CYCLEH: rd_data = counters.cycle_cnt[63:32];
			csr_pkg::ADDR_TIME: rd_data = counters.time_cnt[31:0];
			csr_pkg::ADDR_TIMEH: rd_data = counters.time_cnt[63:32];
			csr_pkg::ADDR_INSTRET: rd_data = counters.instret_cnt[31:0];
			csr_pkg::ADDR_INSTRETH: rd_data = counters.instret_cnt[63:32];
			default: ;
		endcase
	end

	assign exc_handler_addr = stvec;
	assign exc_continue_addr = sepc;

	// user mode always takes supervisor interrupts.
	assign pending = sip & sie;
	assign intr_gate = (mode == csr_pkg::priv_user) || sstatus[csr_pkg::SSTATUS_SIE];
	assign has_intr = |pending && intr_gate;

	always_comb begin
		intr_index = '0;
		for (int i = 0; i < 32; i++) begin
			if (pending[i])
				intr_index = csr_pkg::intr_idx_t'(i); // highest index wins.
		end
	end

endmodule

/* source/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters #(
	parameter int TIMER_DIV = 8
) (
	input logic clk,
	input logic rst,
	input logic inst_retired,
	output csr_pkg::counters_t counters,
	output logic timer_tick
);

	localparam int PW = $clog2(TIMER_DIV);

	logic [PW-1:0] presc;
	logic presc_wrap;

	assign presc_wrap = (presc == PW'(TIMER_DIV - 1));

	// prescaler wraps every TIMER_DIV clocks.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			presc <= '0;
			timer_tick <= 1'b0;
		end else begin
			timer_tick <= presc_wrap; // same edge as time increment.
			if (presc_wrap)
				presc <= '0;
			else
				presc <= presc + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			counters <= '0;
		end else begin
			counters.cycle_cnt <= counters.cycle_cnt + 64'd1;
			if (presc_wrap)
				counters.time_cnt <= counters.time_cnt + 64'd1;
			if (inst_retired)
				counters.instret_cnt <= counters.instret_cnt + 64'd1;
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (rst)
		timer_tick |=> !timer_tick);

endmodule

/* source/priv_fsm.sv */
`timescale 1ns/1ps

module priv_fsm (
	input logic clk,
	input logic rst,
	input logic exception,
	input logic exc_leave,
	input csr_pkg::csr_wr_t wr,
	output csr_pkg::priv_e mode,
	output csr_pkg::csr_data_t sstatus
);

	csr_pkg::priv_e state, state_next;
	csr_pkg::csr_data_t sstatus_q, sstatus_next;

	always_comb begin
		state_next = state;
		sstatus_next = sstatus_q;

		if (exception) begin
			// trap entry.
			sstatus_next[csr_pkg::SSTATUS_SPP] = (state == csr_pkg::priv_super);
			sstatus_next[csr_pkg::SSTATUS_SPIE] = sstatus_q[csr_pkg::SSTATUS_SIE];
			sstatus_next[csr_pkg::SSTATUS_SIE] = 1'b0;
			state_next = csr_pkg::priv_super;
		end else if (exc_leave) begin
			// trap return, back to the mode saved in spp.
			if (sstatus_q[csr_pkg::SSTATUS_SPP])
				state_next = csr_pkg::priv_super;
			else
				state_next = csr_pkg::priv_user;
			sstatus_next[csr_pkg::SSTATUS_SIE] = sstatus_q[csr_pkg::SSTATUS_SPIE];
			sstatus_next[csr_pkg::SSTATUS_SPIE] = 1'b1;
		end else if (wr.en && wr.addr == csr_pkg::ADDR_SSTATUS) begin
			sstatus_next = wr.data; // whole register.
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= csr_pkg::priv_super;
			sstatus_q <= '0;
		end else begin
			state <= state_next;
			sstatus_q <= sstatus_next;
		end
	end

	assign mode = state;
	assign sstatus = sstatus_q;

	// entry takes priority over return.
	a_exc_wins: assert property (@(posedge clk) disable iff (rst)
		exception && exc_leave |=>
			mode == csr_pkg::priv_super && !sstatus[csr_pkg::SSTATUS_SIE]);

endmodule

/* source/csr_apb_slave.sv */
`timescale 1ns/1ps

module csr_apb_slave (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input csr_pkg::csr_addr_t paddr,
	input csr_pkg::csr_data_t pwdata,
	output csr_pkg::csr_data_t prdata,
	output logic pready,
	output logic pslverr,
	input csr_pkg::priv_e mode,
	input csr_pkg::csr_data_t rd_data,
	output csr_pkg::csr_addr_t addr,
	output csr_pkg::csr_wr_t wr
);

	logic first_access; // access phase, wait state cycle.
	logic priv_err;

	assign first_access = psel && penable && !pready;

	// supervisor range is off limits in user mode.
	assign priv_err = (paddr[9:8] == 2'b01) && (mode == csr_pkg::priv_user);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready <= first_access; // one wait state.
			pslverr <= first_access && priv_err;
		end
	end

	always_ff @(posedge clk) begin
		if (first_access)
			prdata <= rd_data;
	end

	assign addr = paddr;

	// commit on the completing edge only.
	assign wr.en = psel && penable && pready && pwrite && !pslverr;
	assign wr.addr = paddr;
	assign wr.data = pwdata;

	a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> psel && penable);

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

	typedef logic [11:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [4:0] intr_idx_t;

	// supervisor registers.
	localparam csr_addr_t ADDR_SSTATUS = 12'h100;
	localparam csr_addr_t ADDR_SIE = 12'h104;
	localparam csr_addr_t ADDR_STVEC = 12'h105;
	localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
	localparam csr_addr_t ADDR_SEPC = 12'h141;
	localparam csr_addr_t ADDR_SCAUSE = 12'h142;
	localparam csr_addr_t ADDR_STVAL = 12'h143;
	localparam csr_addr_t ADDR_SIP = 12'h144;

	// read-only counters, low and high halves.
	localparam csr_addr_t ADDR_CYCLE = 12'hC00;
	localparam csr_addr_t ADDR_TIME = 12'hC01;
	localparam csr_addr_t ADDR_INSTRET = 12'hC02;
	localparam csr_addr_t ADDR_CYCLEH = 12'hC80;
	localparam csr_addr_t ADDR_TIMEH = 12'hC81;
	localparam csr_addr_t ADDR_INSTRETH = 12'hC82;

	localparam int SIP_TIMER_BIT = 5;
	localparam int SIP_EXT_BIT = 1;

	localparam int SSTATUS_SPP = 8;
	localparam int SSTATUS_SPIE = 5;
	localparam int SSTATUS_SIE = 1;

	typedef enum logic {
		priv_user = 1'b0,
		priv_super = 1'b1
	} priv_e;

	typedef struct packed {
		logic en;
		csr_addr_t addr;
		csr_data_t data;
	} csr_wr_t;

	typedef struct packed {
		csr_data_t cause;
		csr_data_t pc;
		csr_data_t value;
	} trap_info_t;

	typedef struct packed {
		logic [63:0] cycle_cnt;
		logic [63:0] time_cnt;
		logic [63:0] instret_cnt;
	} counters_t;

endpackage
